// File: include/cmos_cfg_table.svh
`ifndef CMOS_CFG_TABLE_SVH
`define CMOS_CFG_TABLE_SVH

// ----------------------------------------------------------------------------
// OV5640 power-up register table, RGB565 output
//   0-1    chip ID read
//   2-3    soft reset, then wake
//   4-21   clock, PLL, IO, format and ISP enable
//   22-45  timing; window fields at 28-39 come from the input ports
//   46-59  exposure limits, BLC and DVP clock divider
//   60-63  test pattern off, strobe LED
// ----------------------------------------------------------------------------
7'd0  : tbl_entry = ent_rd(16'h300A, cmos_cfg_pkg::OP_READ_ID_HI);
7'd1  : tbl_entry = ent_rd(16'h300B, cmos_cfg_pkg::OP_READ_ID_LO);
7'd2  : tbl_entry = ent_wr(16'h3008, 8'h82);    // Soft reset, power down
7'd3  : tbl_entry = ent_wr(16'h3008, 8'h02);    // Normal mode
7'd4  : tbl_entry = ent_wr(16'h3103, 8'h02);    // System clock from PLL
7'd5  : tbl_entry = ent_wr(16'h3017, 8'hFF);    // VSYNC/HREF/PCLK/D[9:6] out
7'd6  : tbl_entry = ent_wr(16'h3018, 8'hFF);    // D[5:0] and GPIO out
7'd7  : tbl_entry = ent_wr(16'h3037, 8'h13);    // PLL root divider
7'd8  : tbl_entry = ent_wr(16'h3108, 8'h01);
7'd9  : tbl_entry = ent_wr(16'h3035, 8'h11);    // System clock divider
7'd10 : tbl_entry = ent_wr(16'h3036, 8'h3C);    // PLL multiplier
7'd11 : tbl_entry = ent_wr(16'h302D, 8'h60);
7'd12 : tbl_entry = ent_wr(16'h3000, 8'h00);    // Release block resets
7'd13 : tbl_entry = ent_wr(16'h3004, 8'hFF);    // Enable all block clocks
7'd14 : tbl_entry = ent_wr(16'h4300, 8'h61);    // RGB565
7'd15 : tbl_entry = ent_wr(16'h501F, 8'h01);    // ISP RGB path
7'd16 : tbl_entry = ent_wr(16'h440E, 8'h00);
7'd17 : tbl_entry = ent_wr(16'h5000, 8'hA7);    // ISP enable
7'd18 : tbl_entry = ent_wr(16'h5001, 8'hA3);
7'd19 : tbl_entry = ent_wr(16'h4713, 8'h03);
7'd20 : tbl_entry = ent_wr(16'h4407, 8'h04);
7'd21 : tbl_entry = ent_wr(16'h460C, 8'h22);
7'd22 : tbl_entry = ent_wr(16'h3820, 8'h46);    // Flip and binning
7'd23 : tbl_entry = ent_wr(16'h3821, 8'h01);
7'd24 : tbl_entry = ent_wr(16'h3814, 8'h31);    // Subsample increments
7'd25 : tbl_entry = ent_wr(16'h3815, 8'h31);
7'd26 : tbl_entry = ent_wr(16'h3800, 8'h00);    // H start
7'd27 : tbl_entry = ent_wr(16'h3801, 8'h00);
7'd28 : tbl_entry = ent_fld(16'h3802, cmos_cfg_pkg::FLD_Y_ST_HI);
7'd29 : tbl_entry = ent_fld(16'h3803, cmos_cfg_pkg::FLD_Y_ST_LO);
7'd30 : tbl_entry = ent_fld(16'h3806, cmos_cfg_pkg::FLD_Y_END_HI);
7'd31 : tbl_entry = ent_fld(16'h3807, cmos_cfg_pkg::FLD_Y_END_LO);
7'd32 : tbl_entry = ent_fld(16'h3808, cmos_cfg_pkg::FLD_H_OUT_HI);
7'd33 : tbl_entry = ent_fld(16'h3809, cmos_cfg_pkg::FLD_H_OUT_LO);
7'd34 : tbl_entry = ent_fld(16'h380A, cmos_cfg_pkg::FLD_V_OUT_HI);
7'd35 : tbl_entry = ent_fld(16'h380B, cmos_cfg_pkg::FLD_V_OUT_LO);
7'd36 : tbl_entry = ent_fld(16'h380C, cmos_cfg_pkg::FLD_H_TOT_HI);
7'd37 : tbl_entry = ent_fld(16'h380D, cmos_cfg_pkg::FLD_H_TOT_LO);
7'd38 : tbl_entry = ent_fld(16'h380E, cmos_cfg_pkg::FLD_V_TOT_HI);
7'd39 : tbl_entry = ent_fld(16'h380F, cmos_cfg_pkg::FLD_V_TOT_LO);
7'd40 : tbl_entry = ent_wr(16'h3804, 8'h0A);    // H end
7'd41 : tbl_entry = ent_wr(16'h3805, 8'h3F);
7'd42 : tbl_entry = ent_wr(16'h3810, 8'h00);    // H offset
7'd43 : tbl_entry = ent_wr(16'h3811, 8'h10);
7'd44 : tbl_entry = ent_wr(16'h3812, 8'h00);    // V offset
7'd45 : tbl_entry = ent_wr(16'h3813, 8'h06);
7'd46 : tbl_entry = ent_wr(16'h3A02, 8'h17);    // 60 Hz max exposure
7'd47 : tbl_entry = ent_wr(16'h3A03, 8'h10);
7'd48 : tbl_entry = ent_wr(16'h3A14, 8'h17);    // 50 Hz max exposure
7'd49 : tbl_entry = ent_wr(16'h3A15, 8'h10);
7'd50 : tbl_entry = ent_wr(16'h3A18, 8'h00);    // Gain ceiling
7'd51 : tbl_entry = ent_wr(16'h3A19, 8'hF8);
7'd52 : tbl_entry = ent_wr(16'h3A13, 8'h43);
7'd53 : tbl_entry = ent_wr(16'h3B07, 8'h0A);    // Frame exposure mode
7'd54 : tbl_entry = ent_wr(16'h4001, 8'h02);    // BLC start line
7'd55 : tbl_entry = ent_wr(16'h4004, 8'h02);
7'd56 : tbl_entry = ent_wr(16'h4005, 8'h1A);
7'd57 : tbl_entry = ent_wr(16'h3708, 8'h64);
7'd58 : tbl_entry = ent_wr(16'h4837, 8'h22);    // DVP PCLK period
7'd59 : tbl_entry = ent_wr(16'h3824, 8'h02);    // DVP clock divider
7'd60 : tbl_entry = ent_wr(16'h503D, 8'h00);    // Test pattern off
7'd61 : tbl_entry = ent_wr(16'h3016, 8'h02);    // Strobe pin output
7'd62 : tbl_entry = ent_wr(16'h301C, 8'h02);
7'd63 : tbl_entry = ent_wr(16'h3019, 8'h00);    // Strobe LED off
// Past the end, a harmless read of the ID register
default : tbl_entry = ent_rd(16'h300A, cmos_cfg_pkg::OP_READ_ID_HI);

`endif

// File: logic/cmos_cfg_pkg.sv
package cmos_cfg_pkg;

    // ------------------------------------------------------------------------
    // Widths and counts
    // ------------------------------------------------------------------------
    localparam int REG_ADDR_W = 16;                 // Sensor register address
    localparam int REG_DATA_W = 8;
    localparam int CMD_W      = REG_ADDR_W + REG_DATA_W;
    localparam int PIX_W      = 13;                 // Window inputs
    localparam int REG_COUNT  = 64;
    localparam int IDX_W      = 7;
    localparam int OP_W       = 2;
    localparam int FLD_W      = 4;

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(REG_COUNT - 1);

    // 250 kHz clk, 5000 cycles give the 20 ms the sensor needs after power-up
    localparam logic [12:0] POWER_UP_CYCLES = 13'd5000;

    localparam logic [15:0] CHIP_ID = 16'h5640;     // OV5640 ID at 0x300A/0x300B

    // ------------------------------------------------------------------------
    // Enums
    // ------------------------------------------------------------------------
    typedef enum logic [OP_W-1:0] {
        OP_READ_ID_HI,      // Read 0x300A
        OP_READ_ID_LO,      // Read 0x300B
        OP_WRITE,
        OP_WRITE_FIELD      // Byte comes from a window input
    } cfg_op_e;

    typedef enum logic [FLD_W-1:0] {
        FLD_NONE,
        FLD_Y_ST_HI,
        FLD_Y_ST_LO,
        FLD_Y_END_HI,
        FLD_Y_END_LO,
        FLD_H_OUT_HI,
        FLD_H_OUT_LO,
        FLD_V_OUT_HI,
        FLD_V_OUT_LO,
        FLD_H_TOT_HI,
        FLD_H_TOT_LO,
        FLD_V_TOT_HI,
        FLD_V_TOT_LO
    } win_field_e;

    typedef enum logic [2:0] {
        SEQ_POWER_UP,
        SEQ_LOAD,
        SEQ_ISSUE,
        SEQ_WAIT_DONE,
        SEQ_FINISHED
    } seq_state_e;

    // One table entry packed as {addr, op, byte, field}
    localparam int ENTRY_W = REG_ADDR_W + OP_W + REG_DATA_W + FLD_W;

endpackage

// File: logic/cmos_cfg_sequencer.sv
`timescale 1ns/100ps

module cmos_cfg_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i2c_done,
    output logic [cmos_cfg_pkg::IDX_W-1:0] entry_idx,
    output logic                           i2c_exec,
    output logic                           init_done
);

    cmos_cfg_pkg::seq_state_e                        state;
    cmos_cfg_pkg::seq_state_e                        state_nxt;
    logic [$bits(cmos_cfg_pkg::POWER_UP_CYCLES)-1:0] pwr_cnt;
    logic                                            pwr_up_end;
    logic                                            last_entry;

    assign pwr_up_end = (pwr_cnt == cmos_cfg_pkg::POWER_UP_CYCLES - 1'b1);
    assign last_entry = (entry_idx == cmos_cfg_pkg::LAST_IDX);

    // ------------------------------------------------------------------------
    // Sequencer FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            cmos_cfg_pkg::SEQ_POWER_UP:  if (pwr_up_end) state_nxt = cmos_cfg_pkg::SEQ_ISSUE;
            cmos_cfg_pkg::SEQ_LOAD:      state_nxt = cmos_cfg_pkg::SEQ_ISSUE;
            cmos_cfg_pkg::SEQ_ISSUE:     state_nxt = cmos_cfg_pkg::SEQ_WAIT_DONE;
            cmos_cfg_pkg::SEQ_WAIT_DONE: begin
                if (i2c_done) begin
                    state_nxt = last_entry ? cmos_cfg_pkg::SEQ_FINISHED
                                           : cmos_cfg_pkg::SEQ_LOAD;
                end
            end
            cmos_cfg_pkg::SEQ_FINISHED:  state_nxt = cmos_cfg_pkg::SEQ_FINISHED;
            default:                     state_nxt = cmos_cfg_pkg::SEQ_POWER_UP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cmos_cfg_pkg::SEQ_POWER_UP;
            pwr_cnt   <= '0;
            entry_idx <= '0;
        end else begin
            state <= state_nxt;
            if (state == cmos_cfg_pkg::SEQ_POWER_UP)
                pwr_cnt <= pwr_cnt + 1'b1;
            // Index steps on entry to LOAD, so the decoder has a cycle before ISSUE
            if (state_nxt == cmos_cfg_pkg::SEQ_LOAD)
                entry_idx <= entry_idx + 1'b1;
        end
    end

    assign i2c_exec  = (state == cmos_cfg_pkg::SEQ_ISSUE);     // One cycle per entry
    assign init_done = (state == cmos_cfg_pkg::SEQ_FINISHED);

endmodule

// File: logic/cmos_cfg_reg_decode.sv
`timescale 1ns/100ps

module cmos_cfg_reg_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cmos_cfg_pkg::IDX_W-1:0] entry_idx,
    input  logic [cmos_cfg_pkg::PIX_W-1:0] y_addr_st,
    input  logic [cmos_cfg_pkg::PIX_W-1:0] y_addr_end,
    input  logic [cmos_cfg_pkg::PIX_W-1:0] cmos_h_pixel,
    input  logic [cmos_cfg_pkg::PIX_W-1:0] cmos_v_pixel,
    input  logic [cmos_cfg_pkg::PIX_W-1:0] total_h_pixel,
    input  logic [cmos_cfg_pkg::PIX_W-1:0] total_v_pixel,
    output logic [cmos_cfg_pkg::CMD_W-1:0] i2c_data,
    output logic                           i2c_rh_wl,
    output cmos_cfg_pkg::cfg_op_e          entry_op
);

    logic [cmos_cfg_pkg::ENTRY_W-1:0]    tbl_entry;
    logic [cmos_cfg_pkg::REG_ADDR_W-1:0] tbl_addr;
    logic [cmos_cfg_pkg::OP_W-1:0]       tbl_op_bits;
    logic [cmos_cfg_pkg::REG_DATA_W-1:0] tbl_byte;
    logic [cmos_cfg_pkg::FLD_W-1:0]      tbl_fld_bits;
    cmos_cfg_pkg::cfg_op_e               tbl_op;
    cmos_cfg_pkg::win_field_e            tbl_field;
    logic [cmos_cfg_pkg::REG_DATA_W-1:0] fld_byte;
    logic [cmos_cfg_pkg::REG_DATA_W-1:0] wr_byte;
    logic                                is_read;

    // Entry builders used by the table
    function automatic logic [cmos_cfg_pkg::ENTRY_W-1:0] ent_wr(
        input logic [cmos_cfg_pkg::REG_ADDR_W-1:0] addr,
        input logic [cmos_cfg_pkg::REG_DATA_W-1:0] val
    );
        return {addr, cmos_cfg_pkg::OP_WRITE, val, cmos_cfg_pkg::FLD_NONE};
    endfunction

    function automatic logic [cmos_cfg_pkg::ENTRY_W-1:0] ent_rd(
        input logic [cmos_cfg_pkg::REG_ADDR_W-1:0] addr,
        input cmos_cfg_pkg::cfg_op_e               op
    );
        return {addr, op, {cmos_cfg_pkg::REG_DATA_W{1'b0}}, cmos_cfg_pkg::FLD_NONE};
    endfunction

    function automatic logic [cmos_cfg_pkg::ENTRY_W-1:0] ent_fld(
        input logic [cmos_cfg_pkg::REG_ADDR_W-1:0] addr,
        input cmos_cfg_pkg::win_field_e            field
    );
        return {addr, cmos_cfg_pkg::OP_WRITE_FIELD, {cmos_cfg_pkg::REG_DATA_W{1'b0}}, field};
    endfunction

    // ------------------------------------------------------------------------
    // Table lookup
    // ------------------------------------------------------------------------
    always_comb begin
        case (entry_idx)
            `include "cmos_cfg_table.svh"
        endcase
    end

    always_comb begin
        {tbl_addr, tbl_op_bits, tbl_byte, tbl_fld_bits} = tbl_entry;
        tbl_op    = cmos_cfg_pkg::cfg_op_e'(tbl_op_bits);
        tbl_field = cmos_cfg_pkg::win_field_e'(tbl_fld_bits);
    end

    // Window byte mux with HI bytes zero-padded above the sensor's field width
    always_comb begin
        case (tbl_field)
            cmos_cfg_pkg::FLD_Y_ST_HI:  fld_byte = {3'd0, y_addr_st[12:8]};
            cmos_cfg_pkg::FLD_Y_ST_LO:  fld_byte = y_addr_st[7:0];
            cmos_cfg_pkg::FLD_Y_END_HI: fld_byte = {3'd0, y_addr_end[12:8]};
            cmos_cfg_pkg::FLD_Y_END_LO: fld_byte = y_addr_end[7:0];
            cmos_cfg_pkg::FLD_H_OUT_HI: fld_byte = {4'd0, cmos_h_pixel[11:8]};
            cmos_cfg_pkg::FLD_H_OUT_LO: fld_byte = cmos_h_pixel[7:0];
            cmos_cfg_pkg::FLD_V_OUT_HI: fld_byte = {5'd0, cmos_v_pixel[10:8]};
            cmos_cfg_pkg::FLD_V_OUT_LO: fld_byte = cmos_v_pixel[7:0];
            cmos_cfg_pkg::FLD_H_TOT_HI: fld_byte = {3'd0, total_h_pixel[12:8]};
            cmos_cfg_pkg::FLD_H_TOT_LO: fld_byte = total_h_pixel[7:0];
            cmos_cfg_pkg::FLD_V_TOT_HI: fld_byte = {3'd0, total_v_pixel[12:8]};
            cmos_cfg_pkg::FLD_V_TOT_LO: fld_byte = total_v_pixel[7:0];
            default:                    fld_byte = '0;
        endcase
    end

    assign wr_byte = (tbl_op == cmos_cfg_pkg::OP_WRITE_FIELD) ? fld_byte : tbl_byte;
    assign is_read = (tbl_op == cmos_cfg_pkg::OP_READ_ID_HI) ||
                     (tbl_op == cmos_cfg_pkg::OP_READ_ID_LO);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_rh_wl <= 1'b1;
            entry_op  <= cmos_cfg_pkg::OP_READ_ID_HI;
        end else begin
            i2c_rh_wl <= is_read;
            entry_op  <= tbl_op;
        end
    end

    always_ff @(posedge clk) begin
        i2c_data <= {tbl_addr, wr_byte};    // Address high, data low
    end

endmodule

// File: logic/cmos_cfg_id_check.sv
`timescale 1ns/100ps

module cmos_cfg_id_check (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i2c_done,
    input  logic [cmos_cfg_pkg::REG_DATA_W-1:0] i2c_data_r,
    input  cmos_cfg_pkg::cfg_op_e               entry_op,
    output logic [15:0]                         chip_id,
    output logic                                id_ok
);

    logic lo_loaded;

    // ------------------------------------------------------------------------
    // Capture the ID bytes as each read completes
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chip_id   <= '0;
            lo_loaded <= 1'b0;
        end else if (i2c_done) begin
            case (entry_op)
                cmos_cfg_pkg::OP_READ_ID_HI: chip_id[15:8] <= i2c_data_r;
                cmos_cfg_pkg::OP_READ_ID_LO: begin
                    chip_id[7:0] <= i2c_data_r;
                    lo_loaded    <= 1'b1;
                end
                default: ;                  // Writes return nothing
            endcase
        end
    end

    // Compare once both halves are in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            id_ok <= 1'b0;
        else
            id_ok <= lo_loaded && (chip_id == cmos_cfg_pkg::CHIP_ID);
    end

endmodule

// File: logic/cmos_cfg_top.sv
`timescale 1ns/100ps

module cmos_cfg_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i2c_done,
    input  logic [cmos_cfg_pkg::REG_DATA_W-1:0] i2c_data_r,
    input  logic [cmos_cfg_pkg::PIX_W-1:0]      y_addr_st,
    input  logic [cmos_cfg_pkg::PIX_W-1:0]      y_addr_end,
    input  logic [cmos_cfg_pkg::PIX_W-1:0]      cmos_h_pixel,
    input  logic [cmos_cfg_pkg::PIX_W-1:0]      cmos_v_pixel,
    input  logic [cmos_cfg_pkg::PIX_W-1:0]      total_h_pixel,
    input  logic [cmos_cfg_pkg::PIX_W-1:0]      total_v_pixel,
    output logic                                i2c_exec,
    output logic [cmos_cfg_pkg::CMD_W-1:0]      i2c_data,
    output logic                                i2c_rh_wl,
    output logic                                init_done,
    output logic [15:0]                         chip_id,
    output logic                                id_ok
);

    logic [cmos_cfg_pkg::IDX_W-1:0] entry_idx;
    cmos_cfg_pkg::cfg_op_e          entry_op;

    // Execute: power-up wait and command pacing
    cmos_cfg_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .i2c_done  (i2c_done),
        .entry_idx (entry_idx),
        .i2c_exec  (i2c_exec),
        .init_done (init_done)
    );

    // Decode: table entry to command word
    cmos_cfg_reg_decode u_reg_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .entry_idx     (entry_idx),
        .y_addr_st     (y_addr_st),
        .y_addr_end    (y_addr_end),
        .cmos_h_pixel  (cmos_h_pixel),
        .cmos_v_pixel  (cmos_v_pixel),
        .total_h_pixel (total_h_pixel),
        .total_v_pixel (total_v_pixel),
        .i2c_data      (i2c_data),
        .i2c_rh_wl     (i2c_rh_wl),
        .entry_op      (entry_op)
    );

    cmos_cfg_id_check u_id_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .i2c_done   (i2c_done),
        .i2c_data_r (i2c_data_r),
        .entry_op   (entry_op),
        .chip_id    (chip_id),
        .id_ok      (id_ok)
    );

endmodule

// File: dv/cmos_cfg_tb.sv
`timescale 1ns/100ps

module cmos_cfg_tb;

    logic                                clk;
    logic                                rst_n;
    logic                                i2c_done;
    logic [7:0]                          i2c_data_r;
    logic [cmos_cfg_pkg::PIX_W-1:0]      y_addr_st;
    logic [cmos_cfg_pkg::PIX_W-1:0]      y_addr_end;
    logic [cmos_cfg_pkg::PIX_W-1:0]      cmos_h_pixel;
    logic [cmos_cfg_pkg::PIX_W-1:0]      cmos_v_pixel;
    logic [cmos_cfg_pkg::PIX_W-1:0]      total_h_pixel;
    logic [cmos_cfg_pkg::PIX_W-1:0]      total_v_pixel;
    logic                                i2c_exec;
    logic [cmos_cfg_pkg::CMD_W-1:0]      i2c_data;
    logic                                i2c_rh_wl;
    logic                                init_done;
    logic [15:0]                         chip_id;
    logic                                id_ok;

    integer seed;
    int     cycle;          // Rising edges since reset release
    int     done_cycle;
    int     win_seen;

    cmos_cfg_top dut_i (.*);

    always #5 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s never arrived", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "Stopped on timeout");
    endtask

    // Outputs are read 1 ns after the edge together with the input updates
    task automatic next_cycle();
        @(posedge clk);
        #1;
        cycle++;
    endtask

    // ------------------------------------------------------------------------
    // Model of the window registers
    // ------------------------------------------------------------------------
    function automatic logic window_byte(input logic [15:0] addr, output logic [7:0] val);
        window_byte = 1'b1;
        case (addr)
            16'h3802: val = {3'd0, y_addr_st[12:8]};
            16'h3803: val = y_addr_st[7:0];
            16'h3806: val = {3'd0, y_addr_end[12:8]};
            16'h3807: val = y_addr_end[7:0];
            16'h3808: val = {4'd0, cmos_h_pixel[11:8]};     // Output H is 12 bits wide
            16'h3809: val = cmos_h_pixel[7:0];
            16'h380A: val = {5'd0, cmos_v_pixel[10:8]};     // Output V is 11 bits wide
            16'h380B: val = cmos_v_pixel[7:0];
            16'h380C: val = {3'd0, total_h_pixel[12:8]};
            16'h380D: val = total_h_pixel[7:0];
            16'h380E: val = {3'd0, total_v_pixel[12:8]};
            16'h380F: val = total_v_pixel[7:0];
            default: begin
                val         = 8'h00;
                window_byte = 1'b0;
            end
        endcase
    endfunction

    task automatic check_command(input int n);
        logic [7:0] exp_byte;
        if (n == 0) begin
            check_value(i2c_rh_wl, 1'b1, "entry 0 is a read");
            check_value(i2c_data[23:8], 16'h300A, "entry 0 reads the ID high byte");
        end else if (n == 1) begin
            check_value(i2c_rh_wl, 1'b1, "entry 1 is a read");
            check_value(i2c_data[23:8], 16'h300B, "entry 1 reads the ID low byte");
        end else begin
            check_value(i2c_rh_wl, 1'b0, "entry after the ID reads is a write");
        end
        if (window_byte(i2c_data[23:8], exp_byte)) begin
            check_value(i2c_data[7:0], exp_byte, "window register byte");
            win_seen++;
        end
        if (n == cmos_cfg_pkg::REG_COUNT - 1)
            check_value(i2c_data, 24'h301900, "last command word");
        check_value(init_done, 1'b0, "init_done while commands remain");
    endtask

    // I2C master stand-in with random latency before one done pulse
    task automatic answer_command(input int n);
        int delay;
        delay = 1 + ($unsigned($random(seed)) % 8);
        repeat (delay) begin
            next_cycle();
            check_value(i2c_exec, 1'b0, "i2c_exec while a command is open");
            check_value(init_done, 1'b0, "init_done before the last i2c_done");
        end
        i2c_done = 1'b1;
        case (i2c_data[23:8])
            16'h300A: i2c_data_r = 8'h56;
            16'h300B: i2c_data_r = 8'h40;
            default:  i2c_data_r = 8'($random(seed));      // Writes return junk
        endcase
        done_cycle = cycle;
        next_cycle();
        i2c_done = 1'b0;
        check_value(i2c_exec, 1'b0, "i2c_exec one cycle after i2c_done");
        check_value(init_done, n == cmos_cfg_pkg::REG_COUNT - 1, "init_done after i2c_done");
    endtask

    task automatic wait_exec(input int limit, input int origin, input int gap,
                             input string what);
        int   waited;
        logic found;
        waited = 0;
        found  = 1'b0;
        while (!found && waited < limit) begin
            next_cycle();
            waited++;
            found = i2c_exec;
        end
        if (!found)
            report_timeout(what);
        else
            check_value(cycle - origin, gap, {"cycles before ", what});
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        i2c_done      = 1'b0;
        i2c_data_r    = 8'h00;
        seed          = 95;
        cycle         = 0;
        done_cycle    = 0;
        win_seen      = 0;
        y_addr_st     = cmos_cfg_pkg::PIX_W'($random(seed));
        y_addr_end    = cmos_cfg_pkg::PIX_W'($random(seed));
        cmos_h_pixel  = cmos_cfg_pkg::PIX_W'($random(seed));
        cmos_v_pixel  = cmos_cfg_pkg::PIX_W'($random(seed));
        total_h_pixel = cmos_cfg_pkg::PIX_W'($random(seed));
        total_v_pixel = cmos_cfg_pkg::PIX_W'($random(seed));

        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        check_value(i2c_exec, 1'b0, "i2c_exec after reset");
        check_value(i2c_rh_wl, 1'b1, "i2c_rh_wl after reset");
        check_value(init_done, 1'b0, "init_done after reset");
        check_value(chip_id, 16'h0000, "chip_id after reset");
        check_value(id_ok, 1'b0, "id_ok after reset");

        wait_exec(6000, 0, cmos_cfg_pkg::POWER_UP_CYCLES, "first i2c_exec");
        for (int n = 0; n < cmos_cfg_pkg::REG_COUNT; n++) begin
            check_command(n);
            answer_command(n);
            if (n < cmos_cfg_pkg::REG_COUNT - 1)
                wait_exec(20, done_cycle, 2, "next i2c_exec");
            if (n == 1) begin
                check_value(chip_id, 16'h5640, "chip_id after the ID reads");
                check_value(id_ok, 1'b1, "id_ok after the ID reads");
            end
        end
        check_value(win_seen, 12, "window registers written");

        // Sequencer must stay quiet once finished
        repeat (50) begin
            next_cycle();
            check_value(i2c_exec, 1'b0, "i2c_exec after init_done");
            check_value(init_done, 1'b1, "init_done stays high");
        end
        check_value(chip_id, 16'h5640, "final chip_id");
        check_value(id_ok, 1'b1, "final id_ok");

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
logic/cmos_cfg_pkg.sv
logic/cmos_cfg_sequencer.sv
logic/cmos_cfg_reg_decode.sv
logic/cmos_cfg_id_check.sv
logic/cmos_cfg_top.sv
dv/cmos_cfg_tb.sv

// File: Bender.yml
package:
  name: cmos_cfg

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cmos_cfg_pkg.sv
      - logic/cmos_cfg_sequencer.sv
      - logic/cmos_cfg_reg_decode.sv
      - logic/cmos_cfg_id_check.sv
      - logic/cmos_cfg_top.sv
  - target: test
    files:
      - dv/cmos_cfg_tb.sv
